// ==== rvIsaPkg.sv ====
package rvIsaPkg;

  // ##################################################
  // major opcodes, instr[6:0].
  localparam logic [6:0] opLoad    = 7'b0000011;
  localparam logic [6:0] opLoadFp  = 7'b0000111;
  localparam logic [6:0] opStore   = 7'b0100011;
  localparam logic [6:0] opStoreFp = 7'b0100111;
  localparam logic [6:0] opOp      = 7'b0110011;
  localparam logic [6:0] opOpImm   = 7'b0010011;
  localparam logic [6:0] opOp32    = 7'b0111011;
  localparam logic [6:0] opOpImm32 = 7'b0011011;
  localparam logic [6:0] opLui     = 7'b0110111;
  localparam logic [6:0] opAuipc   = 7'b0010111;
  localparam logic [6:0] opMadd    = 7'b1000011; // fused multiply-add group.
  localparam logic [6:0] opMsub    = 7'b1000111;
  localparam logic [6:0] opNmsub   = 7'b1001011;
  localparam logic [6:0] opNmadd   = 7'b1001111;
  localparam logic [6:0] opOpFp    = 7'b1010011;
  localparam logic [6:0] opBranch  = 7'b1100011;
  localparam logic [6:0] opJal     = 7'b1101111;
  localparam logic [6:0] opJalr    = 7'b1100111;
  localparam logic [6:0] opSystem  = 7'b1110011;

  localparam logic [6:0] funct7MulDiv = 7'b0000001; // M extension on OP and OP-32.

  // compressed quadrants, instr[1:0]. 2'b11 marks a 32-bit instruction.
  localparam logic [1:0] quadC0 = 2'b00;
  localparam logic [1:0] quadC1 = 2'b01;
  localparam logic [1:0] quadC2 = 2'b10;

  localparam logic [4:0] linkRegA = 5'd1; // ra.
  localparam logic [4:0] linkRegB = 5'd5; // t0, alternate link.

  // ##################################################
  // bit positions in the class vector.
  localparam int clsIndir   = 0;
  localparam int clsJump    = 1;
  localparam int clsAlu     = 2;
  localparam int clsShift   = 3;
  localparam int clsMul     = 4;
  localparam int clsLoad    = 5;
  localparam int clsStore   = 6;
  localparam int clsStore2  = 7;
  localparam int clsFpu     = 8;
  localparam int clsLoadFpu = 9;
  localparam int clsSys     = 10;
  localparam int clsPos0    = 11;
  localparam int clsRvc     = 12;

  localparam int classWidth = 13;

endpackage

// ==== predecodePkg.sv ====
package predecodePkg;

  typedef logic [31:0] instrWord; // full instruction or fetch word.
  typedef logic [15:0] halfWord;  // one parcel.
  typedef logic [rvIsaPkg::classWidth-1:0] classVec;

  // link hint, see lnk2 of the predecoder.
  typedef logic [1:0] lnkCode;

  localparam lnkCode lnkNone = 2'b00;
  localparam lnkCode lnkPush = 2'b01; // destination is a link register.
  localparam lnkCode lnkPop  = 2'b10; // source only.
  localparam lnkCode lnkSwap = 2'b11; // both, different registers.

  // ##################################################
  // aligner to predecoder.
  typedef struct packed {
    instrWord instr; // upper half zero for rvc.
    logic     isRvc;
    logic     pos0;  // starts at halfword 0 of its fetch word.
  } alignedInstr;

  // one queue entry.
  typedef struct packed {
    instrWord                          instr;
    logic [rvIsaPkg::classWidth-1:0]   classVec;
    logic                              isLnk;
    logic                              isRet;
    lnkCode                            lnk2;
  } predecResult;

  localparam int queueDepth = 4;
  localparam int queuePtrW  = 2;

endpackage

// ==== parcelAligner.sv ====
`timescale 1ns/1ps

module parcelAligner (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     inReq,
  input  predecodePkg::instrWord   inWord,
  output logic                     inAck,
  input  logic                     queueFull,
  output logic                     instrValid,
  output predecodePkg::alignedInstr aligned
);
  import predecodePkg::*;

  typedef enum logic [1:0] {
    idle,
    capture,
    issue,
    waitReqLow
  } alignState;

  alignState state;
  instrWord  wordQ;     // captured fetch word.
  halfWord   leftQ;     // upper parcel waiting for the next word.
  logic      leftValid;
  logic      ptr;       // 0 low parcel, 1 high parcel.
  halfWord   loHalf;
  halfWord   hiHalf;
  logic      loRvc;
  logic      hiRvc;
  logic      wordDone;
  logic      keepHigh;

  assign loHalf = wordQ[15:0];
  assign hiHalf = wordQ[31:16];
  assign loRvc  = loHalf[1:0] != 2'b11;
  assign hiRvc  = hiHalf[1:0] != 2'b11;

  assign instrValid = (state == issue) && !queueFull;

  // the high parcel starts a 32-bit instruction that ends in the next word.
  assign keepHigh = !ptr && (leftValid || loRvc) && !hiRvc;

  // last instruction of this word goes out this cycle.
  assign wordDone = ptr || (!leftValid && !loRvc) || !hiRvc;

  // ##################################################
  // parcel selection.
  always_comb begin : parcelSelect
    aligned = '0;
    if (state == issue) begin
      if (ptr) begin
        aligned.instr = {16'h0000, hiHalf};
        aligned.isRvc = 1'b1;
        aligned.pos0  = 1'b0;
      end else if (leftValid) begin
        aligned.instr = {loHalf, leftQ}; // spans two fetch words.
        aligned.isRvc = 1'b0;
        aligned.pos0  = 1'b0;
      end else if (loRvc) begin
        aligned.instr = {16'h0000, loHalf};
        aligned.isRvc = 1'b1;
        aligned.pos0  = 1'b1;
      end else begin
        aligned.instr = wordQ;
        aligned.isRvc = 1'b0;
        aligned.pos0  = 1'b1;
      end
    end
  end

  // ##################################################
  // control.
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      inAck     <= 1'b0;
      leftValid <= 1'b0;
      ptr       <= 1'b0;
    end else begin
      if (inAck && !inReq) begin
        inAck <= 1'b0; // source released the request.
      end
      case (state)
        idle: begin
          if (inReq && !inAck && !queueFull) begin
            state <= capture;
            inAck <= 1'b1;
          end
        end
        capture: begin
          state <= issue;
          ptr   <= 1'b0;
        end
        issue: begin
          if (!queueFull) begin
            if (!ptr && (leftValid || loRvc)) begin
              leftValid <= !hiRvc;
            end
            if (wordDone) begin
              ptr   <= 1'b0;
              state <= (inAck && inReq) ? waitReqLow : idle;
            end else begin
              ptr <= 1'b1;
            end
          end
        end
        waitReqLow: begin
          if (!inReq) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // payload.
  always_ff @(posedge clk) begin
    if (state == capture) begin
      wordQ <= inWord; // stable while inAck is high.
    end
    if (state == issue && !queueFull && keepHigh) begin
      leftQ <= hiHalf;
    end
  end

  stallHolds: assert property (@(posedge clk) disable iff (reset)
    state == issue && queueFull |=> $stable(aligned))
    else $error("aligned instruction changed while the queue was full.");

  ackAfterReq: assert property (@(posedge clk) disable iff (reset)
    $rose(inAck) |-> $past(inReq))
    else $error("inAck raised without a pending request.");

endmodule

// ==== predecRvClass.sv ====
`timescale 1ns/1ps

module predecRvClass (
  input  predecodePkg::instrWord instr,
  input  logic                   isRvc,
  input  logic                   pos0,
  output predecodePkg::classVec  classOut,
  output logic                   isLnk,
  output logic                   isRet,
  output predecodePkg::lnkCode   lnk2
);
  import rvIsaPkg::*;
  import predecodePkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [1:0] quad;
  logic [2:0] cFunct3;
  logic [4:0] cRs1;   // also rd in the compressed register forms.
  logic [4:0] cRs2;
  logic       shiftF3;
  classVec    rvcCls;
  classVec    baseCls;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic       linkCapable;
  logic       rdLink;
  logic       rs1Link;

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct7  = instr[31:25];
  assign quad    = instr[1:0];
  assign cFunct3 = instr[15:13];
  assign cRs1    = instr[11:7];
  assign cRs2    = instr[6:2];
  assign shiftF3 = (funct3 == 3'b001) || (funct3 == 3'b101); // sll, srl/sra.

  // ##################################################
  // compressed encodings, rv64.
  always_comb begin : rvcDecode
    rvcCls = '0;
    case (quad)
      quadC0: begin
        case (cFunct3)
          3'b000:         rvcCls[clsAlu]     = 1'b1; // c.addi4spn.
          3'b001:         rvcCls[clsLoadFpu] = 1'b1;
          3'b010, 3'b011: rvcCls[clsLoad]    = 1'b1;
          3'b101:         rvcCls[clsStore2]  = 1'b1; // c.fsd.
          3'b110, 3'b111: rvcCls[clsStore]   = 1'b1;
          default: ;
        endcase
      end
      quadC1: begin
        case (cFunct3)
          3'b100: begin
            if (instr[11] == 1'b0) begin
              rvcCls[clsShift] = 1'b1; // c.srli, c.srai.
            end else begin
              rvcCls[clsAlu] = 1'b1;
            end
          end
          3'b101, 3'b110, 3'b111: rvcCls[clsJump] = 1'b1; // c.j, c.beqz, c.bnez.
          default: rvcCls[clsAlu] = 1'b1; // c.addi, c.addiw, c.li, c.lui.
        endcase
      end
      quadC2: begin
        case (cFunct3)
          3'b000:         rvcCls[clsShift]   = 1'b1; // c.slli.
          3'b001:         rvcCls[clsLoadFpu] = 1'b1;
          3'b010, 3'b011: rvcCls[clsLoad]    = 1'b1;
          3'b100: begin
            if (cRs2 != 5'd0) begin
              rvcCls[clsAlu] = 1'b1; // c.mv, c.add.
            end else if (instr[12] && cRs1 == 5'd0) begin
              rvcCls[clsSys] = 1'b1; // c.ebreak.
            end else begin
              rvcCls[clsJump]  = 1'b1;
              rvcCls[clsIndir] = 1'b1;
            end
          end
          3'b101:         rvcCls[clsStore2]  = 1'b1;
          default:        rvcCls[clsStore]   = 1'b1;
        endcase
      end
      default: ;
    endcase
  end

  // ##################################################
  // 32-bit encodings.
  always_comb begin : baseDecode
    baseCls = '0;
    case (opcode)
      opLoad:    baseCls[clsLoad]    = 1'b1;
      opLoadFp:  baseCls[clsLoadFpu] = 1'b1;
      opStore:   baseCls[clsStore]   = 1'b1;
      opStoreFp: baseCls[clsStore2]  = 1'b1;
      opOp, opOp32: begin
        if (funct7 == funct7MulDiv) begin
          baseCls[clsMul] = 1'b1;
        end else if (shiftF3) begin
          baseCls[clsShift] = 1'b1;
        end else begin
          baseCls[clsAlu] = 1'b1;
        end
      end
      opOpImm, opOpImm32: begin
        if (shiftF3) begin
          baseCls[clsShift] = 1'b1;
        end else begin
          baseCls[clsAlu] = 1'b1;
        end
      end
      opLui, opAuipc: baseCls[clsAlu] = 1'b1;
      opMadd, opMsub, opNmsub, opNmadd, opOpFp: baseCls[clsFpu] = 1'b1;
      opBranch, opJal: baseCls[clsJump] = 1'b1;
      opJalr: begin
        baseCls[clsJump]  = 1'b1;
        baseCls[clsIndir] = 1'b1;
      end
      opSystem: baseCls[clsSys] = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    classOut          = isRvc ? rvcCls : baseCls;
    classOut[clsPos0] = pos0;
    classOut[clsRvc]  = isRvc;
  end

  // ##################################################
  // link and return hints.
  always_comb begin : linkDecode
    rd          = 5'd0;
    rs1         = 5'd0;
    linkCapable = 1'b0;
    if (isRvc) begin
      // c.jr and c.jalr, c.jalr writes ra.
      if (quad == quadC2 && cFunct3 == 3'b100 && cRs2 == 5'd0 &&
          !(instr[12] && cRs1 == 5'd0)) begin
        linkCapable = 1'b1;
        rs1         = cRs1;
        rd          = instr[12] ? linkRegA : 5'd0;
      end
    end else if (opcode == opJal) begin
      linkCapable = 1'b1;
      rd          = instr[11:7]; // no source register.
    end else if (opcode == opJalr) begin
      linkCapable = 1'b1;
      rd          = instr[11:7];
      rs1         = instr[19:15];
    end
  end

  assign rdLink  = linkCapable && (rd == linkRegA || rd == linkRegB);
  assign rs1Link = linkCapable && (rs1 == linkRegA || rs1 == linkRegB);
  assign isLnk   = rdLink;
  assign isRet   = rs1Link && rd == 5'd0;

  always_comb begin
    if (rdLink && rs1Link && rd != rs1) begin
      lnk2 = lnkSwap; // co-routine swap.
    end else if (rdLink) begin
      lnk2 = lnkPush;
    end else if (rs1Link) begin
      lnk2 = lnkPop;
    end else begin
      lnk2 = lnkNone;
    end
  end

  retIsIndir: assert final (!isRet || classOut[clsIndir])
    else $error("return hint on a non-indirect instruction.");

  loadXorStore: assert final (!(classOut[clsLoad] && classOut[clsStore]))
    else $error("load and store class both set.");

endmodule

// ==== predecodeQueue.sv ====
`timescale 1ns/1ps

module predecodeQueue (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      wrEn,
  input  predecodePkg::predecResult wrData,
  output logic                      full,
  output logic                      outReq,
  output predecodePkg::predecResult outData,
  input  logic                      outAck
);
  import predecodePkg::*;

  typedef enum logic [1:0] {
    idle,
    reqHigh,
    waitAckLow
  } outState;

  outState              state;
  predecResult          mem [queueDepth];
  logic [queuePtrW-1:0] wrPtr;
  logic [queuePtrW-1:0] rdPtr;
  logic [queuePtrW:0]   count;
  logic                 push;
  logic                 pop;
  logic                 pending; // something to offer next.

  assign full    = count == (queuePtrW + 1)'(queueDepth);
  assign push    = wrEn && !full;
  assign pop     = (state == reqHigh) && outAck;
  assign pending = (count != '0) || push;
  assign outReq  = state == reqHigh;
  assign outData = mem[rdPtr]; // head entry.

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= wrData;
    end
  end

  // ##################################################
  // pointers and output handshake.
  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      state <= idle;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      case (state)
        idle:       if (pending) state <= reqHigh;
        reqHigh:    if (outAck) state <= waitAckLow; // popped on this edge.
        waitAckLow: if (!outAck) state <= pending ? reqHigh : idle;
        default:    state <= idle;
      endcase
    end
  end

  noWriteWhenFull: assert property (@(posedge clk) disable iff (reset)
    full |-> !wrEn)
    else $error("write into a full queue.");

  headStable: assert property (@(posedge clk) disable iff (reset)
    outReq && $past(outReq) |-> $stable(outData))
    else $error("outData changed while outReq was high.");

endmodule

// ==== predecodeTop.sv ====
`timescale 1ns/1ps

module predecodeTop (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inReq,
  input  predecodePkg::instrWord    inWord,
  output logic                      inAck,
  output logic                      outReq,
  output predecodePkg::predecResult outData,
  input  logic                      outAck
);
  import predecodePkg::*;

  alignedInstr aligned;
  logic        instrValid;
  logic        queueFull;
  classVec     cls;
  logic        isLnk;
  logic        isRet;
  lnkCode      lnk2;
  predecResult result;

  parcelAligner aligner (
    .clk        (clk),
    .reset      (reset),
    .inReq      (inReq),
    .inWord     (inWord),
    .inAck      (inAck),
    .queueFull  (queueFull),
    .instrValid (instrValid),
    .aligned    (aligned)
  );

  predecRvClass classifier (
    .instr    (aligned.instr),
    .isRvc    (aligned.isRvc),
    .pos0     (aligned.pos0),
    .classOut (cls),
    .isLnk    (isLnk),
    .isRet    (isRet),
    .lnk2     (lnk2)
  );

  assign result = '{instr: aligned.instr, classVec: cls, isLnk: isLnk,
                    isRet: isRet, lnk2: lnk2};

  predecodeQueue queue (
    .clk     (clk),
    .reset   (reset),
    .wrEn    (instrValid),
    .wrData  (result),
    .full    (queueFull),
    .outReq  (outReq),
    .outData (outData),
    .outAck  (outAck)
  );

endmodule

// ==== predecodeTbModel.sv ====
`timescale 1ns/1ps

module predecodeTbModel (
  input  predecodePkg::instrWord instr,
  input  logic                   isRvc,
  input  logic                   pos0,
  output predecodePkg::classVec  classOut,
  output logic                   isLnk,
  output logic                   isRet,
  output predecodePkg::lnkCode   lnk2
);
  import rvIsaPkg::*;
  import predecodePkg::*;

  logic [4:0] rvcKey;  // {funct3, quadrant}.
  logic       jumpReg; // c.jr or c.jalr.
  logic [4:0] dst;
  logic [4:0] src;
  logic       dstLink;
  logic       srcLink;

  assign rvcKey  = {instr[15:13], instr[1:0]};
  assign jumpReg = isRvc && rvcKey == 5'b100_10 && instr[6:2] == 5'd0 &&
                   !(instr[12] && instr[11:7] == 5'd0);

  // ##################################################
  // class bits.
  always_comb begin
    classOut = '0;
    if (isRvc) begin
      casez (rvcKey)
        5'b000_00, 5'b0??_01: classOut[clsAlu] = 1'b1;
        5'b001_00, 5'b001_10: classOut[clsLoadFpu] = 1'b1;
        5'b01?_00, 5'b01?_10: classOut[clsLoad] = 1'b1;
        5'b101_00, 5'b101_10: classOut[clsStore2] = 1'b1; // fp stores.
        5'b11?_00, 5'b11?_10: classOut[clsStore] = 1'b1;
        5'b100_01: classOut[instr[11] ? clsAlu : clsShift] = 1'b1;
        5'b101_01, 5'b11?_01: classOut[clsJump] = 1'b1;
        5'b000_10: classOut[clsShift] = 1'b1;
        5'b100_10: begin
          if (instr[6:2] != 5'd0) begin
            classOut[clsAlu] = 1'b1;
          end else if (jumpReg) begin
            classOut[clsJump]  = 1'b1;
            classOut[clsIndir] = 1'b1;
          end else begin
            classOut[clsSys] = 1'b1; // c.ebreak.
          end
        end
        default: ;
      endcase
    end else begin
      case (instr[6:0])
        opLoad:    classOut[clsLoad] = 1'b1;
        opLoadFp:  classOut[clsLoadFpu] = 1'b1;
        opStore:   classOut[clsStore] = 1'b1;
        opStoreFp: classOut[clsStore2] = 1'b1;
        opOp, opOp32, opOpImm, opOpImm32: begin
          if (instr[5] && instr[31:25] == 7'b0000001) begin
            classOut[clsMul] = 1'b1; // only the register forms multiply.
          end else if (instr[13:12] == 2'b01) begin
            classOut[clsShift] = 1'b1;
          end else begin
            classOut[clsAlu] = 1'b1;
          end
        end
        opLui, opAuipc: classOut[clsAlu] = 1'b1;
        opMadd, opMsub, opNmsub, opNmadd, opOpFp: classOut[clsFpu] = 1'b1;
        opBranch, opJal: classOut[clsJump] = 1'b1;
        opJalr: begin
          classOut[clsJump]  = 1'b1;
          classOut[clsIndir] = 1'b1;
        end
        opSystem: classOut[clsSys] = 1'b1;
        default: ;
      endcase
    end
    classOut[clsPos0] = pos0;
    classOut[clsRvc]  = isRvc;
  end

  // link registers seen by the jump, x0 where there is none.
  always_comb begin
    dst = 5'd0;
    src = 5'd0;
    if (jumpReg) begin
      src = instr[11:7];
      dst = instr[12] ? linkRegA : 5'd0;
    end else if (!isRvc && instr[6:0] == opJal) begin
      dst = instr[11:7];
    end else if (!isRvc && instr[6:0] == opJalr) begin
      dst = instr[11:7];
      src = instr[19:15];
    end
  end

  assign dstLink = dst == linkRegA || dst == linkRegB;
  assign srcLink = src == linkRegA || src == linkRegB;
  assign isLnk   = dstLink;
  assign isRet   = srcLink && dst == 5'd0;
  assign lnk2    = {srcLink && !(dstLink && dst == src), dstLink};

endmodule

// ==== predecodeTb.sv ====
`timescale 1ns/1ps

module predecodeTb;
  import rvIsaPkg::*;
  import predecodePkg::*;

  localparam int cyclesPerWord = 40;
  localparam logic [6:0] majorOps [19] = '{opLoad, opLoadFp, opStore, opStoreFp, opOp,
    opOpImm, opOp32, opOpImm32, opLui, opAuipc, opMadd, opMsub, opNmsub, opNmadd,
    opOpFp, opBranch, opJal, opJalr, opSystem};

  logic        clk;
  logic        reset;
  logic        inReq;
  instrWord    inWord;
  logic        inAck;
  logic        outReq;
  predecResult outData;
  logic        outAck;

  int          seed;
  halfWord     halves [$];
  instrWord    words [$];
  alignedInstr expQ [$]; // scoreboard in program order.
  alignedInstr expHead;
  logic        sbEmpty;
  predecResult expResult;
  classVec     mClass;
  logic        mLnk;
  logic        mRet;
  lnkCode      mLnk2;
  int          totalExp;
  int          received;
  int          cycles;
  int          cycleLimit;
  int          slowFrom;
  int          slowTo;

  predecodeTop UUT (
    .clk     (clk),
    .reset   (reset),
    .inReq   (inReq),
    .inWord  (inWord),
    .inAck   (inAck),
    .outReq  (outReq),
    .outData (outData),
    .outAck  (outAck)
  );

  predecodeTbModel refModel (
    .instr    (expHead.instr),
    .isRvc    (expHead.isRvc),
    .pos0     (expHead.pos0),
    .classOut (mClass),
    .isLnk    (mLnk),
    .isRet    (mRet),
    .lnk2     (mLnk2)
  );

  assign expResult = '{instr: expHead.instr, classVec: mClass, isLnk: mLnk,
                       isRet: mRet, lnk2: mLnk2};

  always #2 clk = ~clk;

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped on the first error.");
  endtask

  task automatic flagMismatch(input string what);
    abortRun($sformatf("mismatch at %0t ns: %s", $time, what));
  endtask

  // ##################################################
  // stream construction.
  task automatic addInstr(input instrWord ins, input logic rvc);
    alignedInstr a;
    a.isRvc = rvc;
    a.pos0  = halves.size() % 2 == 0; // even halfword is the low parcel.
    a.instr = rvc ? {16'h0000, ins[15:0]} : ins;
    expQ.push_back(a);
    halves.push_back(ins[15:0]);
    if (!rvc) begin
      halves.push_back(ins[31:16]);
    end
  endtask

  function automatic instrWord randWide(input logic [6:0] op);
    instrWord r;
    r = $random(seed);
    return {r[31:7], op};
  endfunction

  function automatic instrWord randShort();
    instrWord r;
    r = $random(seed);
    if (r[1:0] == 2'b11) begin
      r[1:0] = 2'b10; // keep it compressed.
    end
    return {16'h0000, r[15:0]};
  endfunction

  task automatic addRandom(input int count);
    instrWord ins;
    int       pick;
    repeat (count) begin
      pick = $unsigned($random(seed)) % 4;
      case (pick)
        0, 1: addInstr(randShort(), 1'b1);
        2: addInstr(randWide(majorOps[$unsigned($random(seed)) % 19]), 1'b0);
        default: begin
          ins      = $random(seed);
          ins[1:0] = 2'b11;
          addInstr(ins, 1'b0);
        end
      endcase
    end
  endtask

  task automatic buildStream();
    instrWord ins;
    int       k;
    foreach (majorOps[i]) begin
      addInstr(randWide(majorOps[i]), 1'b0);
    end
    ins         = randWide(opOp);
    ins[31:25]  = 7'b0000001; // mul group.
    addInstr(ins, 1'b0);
    ins         = randWide(opOp32);
    ins[31:25]  = 7'b0000001;
    addInstr(ins, 1'b0);
    addInstr(32'h0000_4501, 1'b1); // c.li a0, 0.
    addInstr(32'h0005_3703, 1'b0); // ld spanning two words.
    addInstr(32'h0000_952E, 1'b1); // c.add.
    addInstr(32'h0000_0001, 1'b1);
    addInstr(32'h0080_00EF, 1'b0); // jal ra.
    addInstr(32'h0005_02E7, 1'b0); // jalr t0, 0(a0).
    addInstr(32'h0000_9502, 1'b1); // c.jalr a0.
    addInstr(32'h0000_8082, 1'b1); // c.jr ra.
    addInstr(32'h0002_8067, 1'b0); // jalr x0, 0(t0).
    addInstr(32'h0002_80E7, 1'b0);
    addInstr(32'h0000_006F, 1'b0); // plain jumps from here.
    addInstr(32'h0000_A001, 1'b1);
    addInstr(32'h0003_0067, 1'b0);
    slowFrom = expQ.size();
    addRandom(80);
    slowTo = expQ.size();
    addRandom(100);
    if (halves.size() % 2 != 0) begin
      addInstr(32'h0000_0001, 1'b1); // c.nop closes the last word.
    end
    for (k = 0; k < halves.size(); k += 2) begin
      words.push_back({halves[k+1], halves[k]});
    end
  endtask

  function automatic void refreshHead();
    sbEmpty = expQ.size() == 0;
    expHead = sbEmpty ? '0 : expQ[0];
  endfunction

  task automatic popExpected();
    if (expQ.size() != 0) begin
      void'(expQ.pop_front());
    end
    received++;
    refreshHead();
  endtask

  task automatic sendWord(input instrWord w);
    inWord = w;
    inReq  = 1'b1;
    do @(negedge clk); while (!inAck);
    inReq = 1'b0;
    do @(negedge clk); while (inAck);
  endtask

  // ##################################################
  // producer and end of run.
  initial begin : mainFlow
    clk      = 1'b0;
    reset    = 1'b1;
    inReq    = 1'b0;
    inWord   = '0;
    outAck   = 1'b0;
    seed     = 75545;
    received = 0;
    buildStream();
    totalExp   = expQ.size();
    cycleLimit = cyclesPerWord * words.size();
    refreshHead();
    repeat (10) @(negedge clk);
    reset = 1'b0;
    foreach (words[w]) begin
      sendWord(words[w]);
    end
    wait (received == totalExp);
    repeat (8) @(negedge clk); // stray results would show here.
    if (received == totalExp && sbEmpty && !outReq) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abortRun("results left over or missing at the end of the run.");
    end
  end

  // the consumer slows down inside the back-pressure window.
  initial begin : consumer
    int delay;
    wait (reset === 1'b0);
    forever begin
      @(negedge clk);
      if (outReq) begin
        delay = $unsigned($random(seed)) % ((received >= slowFrom && received < slowTo) ? 13 : 3);
        repeat (delay) @(negedge clk);
        outAck = 1'b1;
        do @(negedge clk); while (outReq);
        outAck = 1'b0;
        popExpected();
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycleLimit != 0 && cycles > cycleLimit) begin
      abortRun("timeout: results still outstanding at the cycle limit.");
    end
  end

  // ##################################################
  // checks.
  resetQuiet: assert property (@(posedge clk) $fell(reset) |-> !inAck && !outReq)
    else abortRun("inAck or outReq high right after reset.");

  inAckRise: assert property (@(posedge clk) disable iff (reset)
    $rose(inAck) |-> $past(inReq))
    else abortRun("inAck rose without a request.");

  inAckFall: assert property (@(posedge clk) disable iff (reset)
    $fell(inAck) |-> !$past(inReq))
    else abortRun("inAck dropped before inReq was released.");

  outReqRise: assert property (@(posedge clk) disable iff (reset)
    $rose(outReq) |-> !$past(outAck))
    else abortRun("outReq rose while outAck was still high.");

  outReqFall: assert property (@(posedge clk) disable iff (reset)
    $fell(outReq) |-> $past(outAck))
    else abortRun("outReq dropped without an acknowledge.");

  outDataHeld: assert property (@(posedge clk) disable iff (reset)
    outReq && $past(outReq) |-> $stable(outData))
    else flagMismatch("outData changed while outReq was high.");

  resultExpected: assert property (@(posedge clk) disable iff (reset) outReq |-> !sbEmpty)
    else abortRun("a result arrived with no instruction left in the scoreboard.");

  resultMatches: assert property (@(posedge clk) disable iff (reset)
    outReq && outAck |-> outData == expResult)
    else flagMismatch($sformatf("expected %h, got %h.", $sampled(expResult),
                                $sampled(outData)));

  loadStoreApart: assert property (@(posedge clk) disable iff (reset)
    outReq |-> !(outData.classVec[clsLoad] && outData.classVec[clsStore]))
    else flagMismatch("load and store class both set.");

  retIsIndirect: assert property (@(posedge clk) disable iff (reset)
    outReq && outData.isRet |-> outData.classVec[clsIndir])
    else flagMismatch("return hint without the indirect class.");

endmodule

// ==== predecode.f ====
rvIsaPkg.sv
predecodePkg.sv
parcelAligner.sv
predecRvClass.sv
predecodeQueue.sv
predecodeTop.sv
predecodeTbModel.sv
predecodeTb.sv

// ==== Bender.yml ====
package:
  name: predecode

sources:
  - rvIsaPkg.sv
  - predecodePkg.sv
  - parcelAligner.sv
  - predecRvClass.sv
  - predecodeQueue.sv
  - predecodeTop.sv
  - target: test
    files:
      - predecodeTbModel.sv
      - predecodeTb.sv
